//--- rp_fe_pkg.sv
package rp_fe_pkg;

  //////////////////////////////////////////////////////////////////////
  // analog channels and sample widths
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned N_CH      = 2;            // ADC / DAC channels
  localparam int unsigned ADC_RAW_W = 16;           // word on the ADC pins
  localparam int unsigned ADC_DROP  = 2;            // reserved LSBs of the 16 bit ADC
  localparam int unsigned SMP_W     = 14;           // stream sample width
  localparam int unsigned SUM_W     = SMP_W + 1;    // one guard bit for asg + pid

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  localparam int unsigned BUS_AW = 32;              // address width
  localparam int unsigned BUS_DW = 32;              // data width

  // region field sits at addr[22:20]
  localparam int unsigned REGION_LSB = 20;
  localparam int unsigned REGION_W   = 3;
  localparam int unsigned N_REGION   = 1 << REGION_W;  // 8 slots

  // housekeeping block
  localparam int unsigned HK_REGION = 0;

  // byte offsets inside the region, sized to the offset field
  localparam logic [REGION_LSB-1:0] HK_ID_OFS   = 'h0;  // id word
  localparam logic [REGION_LSB-1:0] HK_LOOP_OFS = 'h4;  // digital loop flag

  localparam logic [BUS_DW-1:0] HK_ID_VALUE = 32'h5250_0e14;  // fixed id

  //////////////////////////////////////////////////////////////////////
  // shared types
  //////////////////////////////////////////////////////////////////////

  typedef logic        [ADC_RAW_W-1:0] raw_t;       // raw ADC word, unsigned
  typedef logic signed [SMP_W-1:0]     smp_t;       // two's complement sample
  typedef logic signed [SUM_W-1:0]     sum_t;       // sum before saturation
  typedef logic        [BUS_DW-1:0]    bus_word_t;  // one bus word

endpackage : rp_fe_pkg

//--- adc_input_stage.sv
`timescale 1ns/1ps

module adc_input_stage (
  // clock and reset
  input  logic                                   adc_clk,
  input  logic                                   rst_n_i,
  // ADC pins
  input  rp_fe_pkg::raw_t [rp_fe_pkg::N_CH-1:0]  adc_dat_i,
  // digital loopback
  input  logic                                   loop_en_i,   // from housekeeping
  input  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]  loop_dat_i,  // saturated DAC sum
  // sample stream
  output rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]  adc_dat_o
);

  //////////////////////////////////////////////////////////////////////
  // input register
  //////////////////////////////////////////////////////////////////////

  // one word per channel, reserved LSBs already dropped
  logic [rp_fe_pkg::N_CH-1:0][rp_fe_pkg::SMP_W-1:0] adc_raw;

  // meant to land in the IOB flops
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      adc_raw <= '0;
    end
    else
    begin
      for (int i = 0; i < rp_fe_pkg::N_CH; i++)
      begin
        // keep bits 15..2
        adc_raw[i] <= adc_dat_i[i][rp_fe_pkg::ADC_RAW_W-1:rp_fe_pkg::ADC_DROP];
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // code conversion and loopback select
  //////////////////////////////////////////////////////////////////////

  // negative slope code -> two's complement
  // msb stays, the rest is inverted
  always_comb
  begin
    for (int i = 0; i < rp_fe_pkg::N_CH; i++)
    begin
      if (loop_en_i)
      begin
        adc_dat_o[i] = loop_dat_i[i];  // DAC sum replaces the ADC
      end
      else
      begin
        adc_dat_o[i] = {adc_raw[i][rp_fe_pkg::SMP_W-1],
                        ~adc_raw[i][rp_fe_pkg::SMP_W-2:0]};
      end
    end
  end

endmodule : adc_input_stage

//--- dac_mixer.sv
`timescale 1ns/1ps

module dac_mixer (
  // clock and reset
  input  logic                                                adc_clk,
  input  logic                                                rst_n_i,
  // sample sources
  input  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]               asg_dat_i,   // generator
  input  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]               pid_dat_i,   // controller
  // loopback tap
  output rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]               loop_dat_o,
  // DAC pins, one bus per channel
  output logic [rp_fe_pkg::N_CH-1:0][rp_fe_pkg::SMP_W-1:0]    dac_dat_o
);

  rp_fe_pkg::sum_t [rp_fe_pkg::N_CH-1:0] dac_sum;  // full range sum
  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0] dac_sat;  // clamped to 14 bits

  //////////////////////////////////////////////////////////////////////
  // sum and saturation
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int i = 0; i < rp_fe_pkg::N_CH; i++)
    begin
      // both operands signed, sign extended to SUM_W
      dac_sum[i] = $signed(asg_dat_i[i]) + $signed(pid_dat_i[i]);

      // top two bits differ -> out of range
      if (dac_sum[i][rp_fe_pkg::SUM_W-1] != dac_sum[i][rp_fe_pkg::SUM_W-2])
      begin
        // 0x1fff for positive overflow, 0x2000 for negative
        dac_sat[i] = {dac_sum[i][rp_fe_pkg::SUM_W-1],
                      {(rp_fe_pkg::SMP_W-1){~dac_sum[i][rp_fe_pkg::SUM_W-1]}}};
      end
      else
      begin
        dac_sat[i] = dac_sum[i][rp_fe_pkg::SMP_W-1:0];  // fits, just truncate
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // pipeline registers
  //////////////////////////////////////////////////////////////////////

  // stage 1: saturated sum, also feeds the ADC loopback
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_dat_o <= '0;
    end
    else
    begin
      loop_dat_o <= dac_sat;
    end
  end

  // stage 2: signed -> offset binary, negative slope
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_dat_o <= '0;
    end
    else
    begin
      for (int i = 0; i < rp_fe_pkg::N_CH; i++)
      begin
        dac_dat_o[i] <= {loop_dat_o[i][rp_fe_pkg::SMP_W-1],
                         ~loop_dat_o[i][rp_fe_pkg::SMP_W-2:0]};  // invert low 13
      end
    end
  end

endmodule : dac_mixer

//--- sys_bus_decoder.sv
`timescale 1ns/1ps

module sys_bus_decoder (
  // clock and reset
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // master side
  input  rp_fe_pkg::bus_word_t  sys_addr_i,   // held until ack
  input  logic                  sys_wen_i,    // single cycle pulse
  input  logic                  sys_ren_i,    // single cycle pulse
  output rp_fe_pkg::bus_word_t  sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // housekeeping slave (region 0)
  output logic                  hk_wen_o,
  output logic                  hk_ren_o,
  input  rp_fe_pkg::bus_word_t  hk_rdata_i,
  input  logic                  hk_ack_i,
  input  logic                  hk_err_i
);

  logic [rp_fe_pkg::BUS_AW-1:0]   addr;    // address as seen by the decoder
  logic [rp_fe_pkg::REGION_W-1:0] region;  // addr[22:20]
  logic [rp_fe_pkg::N_REGION-1:0] cs;      // one-hot chip select

  // per region return paths
  rp_fe_pkg::bus_word_t [rp_fe_pkg::N_REGION-1:0] rdata_vec;
  logic [rp_fe_pkg::N_REGION-1:0]                 ack_vec;
  logic [rp_fe_pkg::N_REGION-1:0]                 err_vec;

  logic req;       // pulse this cycle
  logic req_pend;  // request issued, ack still due

  //////////////////////////////////////////////////////////////////////
  // region decode
  //////////////////////////////////////////////////////////////////////

  assign addr   = sys_addr_i;
  assign region = addr[rp_fe_pkg::REGION_LSB +: rp_fe_pkg::REGION_W];

  always_comb
  begin
    cs         = '0;
    cs[region] = 1'b1;
  end

  // enables only reach the selected slave
  assign hk_wen_o = sys_wen_i & cs[rp_fe_pkg::HK_REGION];
  assign hk_ren_o = sys_ren_i & cs[rp_fe_pkg::HK_REGION];

  //////////////////////////////////////////////////////////////////////
  // return multiplexer
  //////////////////////////////////////////////////////////////////////

  always_comb
  begin
    for (int r = 0; r < rp_fe_pkg::N_REGION; r++)
    begin
      if (r == rp_fe_pkg::HK_REGION)
      begin
        rdata_vec[r] = hk_rdata_i;
        ack_vec[r]   = hk_ack_i;
        err_vec[r]   = hk_err_i;
      end
      else
      begin
        rdata_vec[r] = '0;    // unused slot
        ack_vec[r]   = 1'b1;  // answers at once
        err_vec[r]   = 1'b0;
      end
    end
  end

  assign req = sys_wen_i | sys_ren_i;

  // ack and err only count while a request is open
  assign sys_rdata_o = rdata_vec[region];
  assign sys_ack_o   = |(cs & ack_vec) & (req | req_pend);
  assign sys_err_o   = |(cs & err_vec) & (req | req_pend);

  // open request tracker, closed by the ack
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      req_pend <= 1'b0;
    end
    else if (sys_ack_o)
    begin
      req_pend <= 1'b0;
    end
    else if (req)
    begin
      req_pend <= 1'b1;  // slave answers later
    end
  end

endmodule : sys_bus_decoder

//--- housekeeping_regs.sv
`timescale 1ns/1ps

module housekeeping_regs (
  // clock and reset
  input  logic                  adc_clk,
  input  logic                  rst_n_i,
  // system bus, enables already gated by region
  input  rp_fe_pkg::bus_word_t  sys_addr_i,
  input  rp_fe_pkg::bus_word_t  sys_wdata_i,
  input  logic                  sys_wen_i,
  input  logic                  sys_ren_i,
  output rp_fe_pkg::bus_word_t  sys_rdata_o,
  output logic                  sys_ack_o,
  output logic                  sys_err_o,
  // global configuration
  output logic                  loop_en_o    // digital loopback
);

  logic [rp_fe_pkg::REGION_LSB-1:0] ofs;  // byte offset in the region

  assign ofs = sys_addr_i[rp_fe_pkg::REGION_LSB-1:0];

  //////////////////////////////////////////////////////////////////////
  // write side
  //////////////////////////////////////////////////////////////////////

  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      loop_en_o <= 1'b0;
    end
    else if (sys_wen_i && (ofs == rp_fe_pkg::HK_LOOP_OFS))
    begin
      loop_en_o <= sys_wdata_i[0];  // only bit 0 is kept
    end
  end

  //////////////////////////////////////////////////////////////////////
  // read side and ack
  //////////////////////////////////////////////////////////////////////

  // ack one cycle after either pulse
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      sys_ack_o <= 1'b0;
    end
    else
    begin
      sys_ack_o <= sys_wen_i | sys_ren_i;
    end
  end

  // read data, updated on read pulses only
  always_ff @(posedge adc_clk)
  begin
    if (sys_ren_i)
    begin
      case (ofs)
        rp_fe_pkg::HK_ID_OFS:   sys_rdata_o <= rp_fe_pkg::HK_ID_VALUE;
        rp_fe_pkg::HK_LOOP_OFS: sys_rdata_o <= {{(rp_fe_pkg::BUS_DW-1){1'b0}}, loop_en_o};
        default:                sys_rdata_o <= '0;  // unmapped offset
      endcase
    end
  end

  assign sys_err_o = 1'b0;  // every offset is legal

endmodule : housekeeping_regs

//--- rp_frontend_top.sv
`timescale 1ns/1ps

module rp_frontend_top (
  // clock and reset
  input  logic                                              adc_clk,
  input  logic                                              rst_n_i,
  // ADC
  input  rp_fe_pkg::raw_t [rp_fe_pkg::N_CH-1:0]             adc_dat_i,   // raw pins
  // generator and controller streams
  input  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             asg_dat_i,
  input  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             pid_dat_i,
  // converted ADC stream
  output rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             adc_dat_o,
  // DAC
  output logic [rp_fe_pkg::N_CH-1:0][rp_fe_pkg::SMP_W-1:0]  dac_dat_o,   // offset binary
  output logic                                              dac_rst_o,   // active high
  // system bus
  input  rp_fe_pkg::bus_word_t                              sys_addr_i,
  input  rp_fe_pkg::bus_word_t                              sys_wdata_i,
  input  logic                                              sys_wen_i,
  input  logic                                              sys_ren_i,
  output rp_fe_pkg::bus_word_t                              sys_rdata_o,
  output logic                                              sys_ack_o,
  output logic                                              sys_err_o
);

  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0] loop_dat;  // saturated sum, registered
  logic                                  loop_en;   // digital loop flag

  // housekeeping slave port
  logic                 hk_wen, hk_ren;
  rp_fe_pkg::bus_word_t hk_rdata;
  logic                 hk_ack, hk_err;

  //////////////////////////////////////////////////////////////////////
  // sample path
  //////////////////////////////////////////////////////////////////////

  adc_input_stage i_adc (
    .adc_clk    (adc_clk  ),
    .rst_n_i    (rst_n_i  ),
    .adc_dat_i  (adc_dat_i),
    .loop_en_i  (loop_en  ),
    .loop_dat_i (loop_dat ),  // DAC -> ADC loop
    .adc_dat_o  (adc_dat_o)
  );

  dac_mixer i_dac (
    .adc_clk    (adc_clk  ),
    .rst_n_i    (rst_n_i  ),
    .asg_dat_i  (asg_dat_i),
    .pid_dat_i  (pid_dat_i),
    .loop_dat_o (loop_dat ),
    .dac_dat_o  (dac_dat_o)
  );

  // DAC reset, set by reset, drops on the first edge after release
  always_ff @(posedge adc_clk or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      dac_rst_o <= 1'b1;
    end
    else
    begin
      dac_rst_o <= 1'b0;
    end
  end

  //////////////////////////////////////////////////////////////////////
  // system bus
  //////////////////////////////////////////////////////////////////////

  sys_bus_decoder i_dec (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .sys_addr_i  (sys_addr_i ),
    .sys_wen_i   (sys_wen_i  ),
    .sys_ren_i   (sys_ren_i  ),
    .sys_rdata_o (sys_rdata_o),
    .sys_ack_o   (sys_ack_o  ),
    .sys_err_o   (sys_err_o  ),
    .hk_wen_o    (hk_wen     ),
    .hk_ren_o    (hk_ren     ),
    .hk_rdata_i  (hk_rdata   ),
    .hk_ack_i    (hk_ack     ),
    .hk_err_i    (hk_err     )
  );

  housekeeping_regs i_hk (
    .adc_clk     (adc_clk    ),
    .rst_n_i     (rst_n_i    ),
    .sys_addr_i  (sys_addr_i ),
    .sys_wdata_i (sys_wdata_i),
    .sys_wen_i   (hk_wen     ),  // region 0 only
    .sys_ren_i   (hk_ren     ),
    .sys_rdata_o (hk_rdata   ),
    .sys_ack_o   (hk_ack     ),
    .sys_err_o   (hk_err     ),
    .loop_en_o   (loop_en    )
  );

endmodule : rp_frontend_top

//--- rp_frontend_props.sv
`timescale 1ns/1ps

module rp_frontend_props (
  input logic                                              adc_clk,
  input logic                                              rst_n_i,
  input rp_fe_pkg::raw_t [rp_fe_pkg::N_CH-1:0]             adc_dat_i,
  input rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             asg_dat_i,
  input rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             pid_dat_i,
  input rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             adc_dat_o,
  input logic [rp_fe_pkg::N_CH-1:0][rp_fe_pkg::SMP_W-1:0]  dac_dat_o,
  input logic                                              dac_rst_o,
  input rp_fe_pkg::bus_word_t                              sys_addr_i,
  input logic                                              sys_wen_i,
  input logic                                              sys_ren_i,
  input rp_fe_pkg::bus_word_t                              sys_rdata_o,
  input logic                                              sys_ack_o,
  input logic                                              sys_err_o,
  input logic                                              loop_en     // top level internal
);

  int unsigned fail_cnt = 0;  // summed up by the testbench
  logic        hk_sel;        // address in region 0
  logic        hk_req;        // pulse towards housekeeping

  assign hk_sel = (sys_addr_i[rp_fe_pkg::REGION_LSB +: rp_fe_pkg::REGION_W]
                   == 3'(rp_fe_pkg::HK_REGION));
  assign hk_req = (sys_wen_i | sys_ren_i) & hk_sel;

  task automatic flag_fail(input string sig, input logic [31:0] val);
    $error("[ERROR] %s = 0x%h, not the expected value", sig, val);
    fail_cnt++;
  endtask

  // signed sum clamped to 0x2000..0x1fff
  function automatic logic [rp_fe_pkg::SMP_W-1:0] clamp_sum(input rp_fe_pkg::smp_t a,
                                                           input rp_fe_pkg::smp_t b);
    int s;
    s = int'(a) + int'(b);
    if (s > 8191)
      s = 8191;
    else if (s < -8192)
      s = -8192;
    return s[rp_fe_pkg::SMP_W-1:0];
  endfunction

  a_reset : assert property (@(posedge adc_clk)
    !rst_n_i |-> dac_rst_o && dac_dat_o == '0 && !sys_ack_o && !sys_err_o)
    else flag_fail("dac_dat_o,sys_ack_o,sys_err_o,dac_rst_o",
                   {1'b0, dac_dat_o, sys_ack_o, sys_err_o, dac_rst_o});

  a_dac_rst : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    $past(rst_n_i) |-> !dac_rst_o) else flag_fail("dac_rst_o", {31'h0, dac_rst_o});

  for (genvar i = 0; i < rp_fe_pkg::N_CH; i++)
  begin : g_ch
    // negative slope code, low 13 bits flipped
    a_adc : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      $past(rst_n_i) && !loop_en |-> adc_dat_o[i]
        == ($past(adc_dat_i[i][rp_fe_pkg::ADC_RAW_W-1:rp_fe_pkg::ADC_DROP]) ^ 14'h1fff))
      else flag_fail($sformatf("adc_dat_o[%0d]", i), {18'h0, adc_dat_o[i]});
    a_loop : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      $past(rst_n_i) && loop_en |-> adc_dat_o[i]
        == clamp_sum($past(asg_dat_i[i]), $past(pid_dat_i[i])))
      else flag_fail($sformatf("adc_dat_o[%0d] in loopback", i), {18'h0, adc_dat_o[i]});
    a_dac : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
      $past(rst_n_i, 2) |-> dac_dat_o[i]
        == (clamp_sum($past(asg_dat_i[i], 2), $past(pid_dat_i[i], 2)) ^ 14'h1fff))
      else flag_fail($sformatf("dac_dat_o[%0d]", i), {18'h0, dac_dat_o[i]});
  end

  // region 0 acks exactly one edge after the pulse
  a_hk_ack : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    hk_req || $past(hk_req) |-> sys_ack_o == $past(hk_req) && !sys_err_o)
    else flag_fail("sys_ack_o", {31'h0, sys_ack_o});

  a_free_region : assert property (@(posedge adc_clk) disable iff (!rst_n_i)
    (sys_wen_i || sys_ren_i) && !hk_sel |-> sys_ack_o && !sys_err_o && sys_rdata_o == '0)
    else flag_fail("sys_rdata_o", sys_rdata_o);

endmodule : rp_frontend_props

//--- rp_frontend_tb.sv
`timescale 1ns/1ps

module rp_frontend_tb;

  localparam int RST_CYC   = 16;
  localparam int PHASE_CYC = 300;                            // random samples per phase
  localparam int TEST_CYC  = RST_CYC + 3 * PHASE_CYC + 120;  // plus bus traffic
  localparam int LIMIT_CYC = 2 * TEST_CYC;

  logic                                              adc_clk = 1'b0;
  logic                                              rst_n_i = 1'b1;  // dropped at 1 ns
  rp_fe_pkg::raw_t [rp_fe_pkg::N_CH-1:0]             adc_dat_i;
  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             asg_dat_i;
  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             pid_dat_i;
  rp_fe_pkg::smp_t [rp_fe_pkg::N_CH-1:0]             adc_dat_o;
  logic [rp_fe_pkg::N_CH-1:0][rp_fe_pkg::SMP_W-1:0]  dac_dat_o;
  logic                                              dac_rst_o;
  rp_fe_pkg::bus_word_t                              sys_addr_i;
  rp_fe_pkg::bus_word_t                              sys_wdata_i;
  rp_fe_pkg::bus_word_t                              sys_rdata_o;
  logic                                              sys_wen_i;
  logic                                              sys_ren_i;
  logic                                              sys_ack_o;
  logic                                              sys_err_o;

  logic [31:0] seed       = 32'h1080856d;
  logic [31:0] rd;                // write responses are ignored
  int          cycles     = 0;
  int          bus_checks = 0;
  int          bus_errs   = 0;

  rp_frontend_top UUT (.*);

  bind rp_frontend_top rp_frontend_props u_props (.*);

  always #4 adc_clk = ~adc_clk;  // 8 ns

  function automatic logic [31:0] xorshift32(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  //////////////////////////////////////////////////////////////////////
  // sample streams
  //////////////////////////////////////////////////////////////////////

  initial
  begin
    adc_dat_i = '0;
    asg_dat_i = '0;
    pid_dat_i = '0;
    forever
    begin
      @(negedge adc_clk);
      for (int i = 0; i < rp_fe_pkg::N_CH; i++)
      begin
        seed         = xorshift32(seed);
        adc_dat_i[i] = seed[15:0];
        seed         = xorshift32(seed);
        asg_dat_i[i] = seed[13:0];
        pid_dat_i[i] = seed[29:16];
        if (seed % 3 == 0)
        begin
          // both near the same rail so the sum clamps
          asg_dat_i[i] = {(seed[30] ? 6'b011111 : 6'b100000), seed[7:0]};
          pid_dat_i[i] = {(seed[30] ? 6'b011111 : 6'b100000), seed[15:8]};
        end
      end
    end
  end

  //////////////////////////////////////////////////////////////////////
  // bus master
  //////////////////////////////////////////////////////////////////////

  // single pulse with the address held until ack
  task automatic bus_access(input logic wr, input logic [31:0] addr,
                            input logic [31:0] wdata, output logic [31:0] rdata);
    int wait_cyc;
    wait_cyc = 0;
    @(negedge adc_clk);
    sys_addr_i  = addr;
    sys_wdata_i = wdata;
    sys_wen_i   = wr;
    sys_ren_i   = !wr;
    @(negedge adc_clk);
    while (!sys_ack_o && wait_cyc < 16)
    begin
      sys_wen_i = 1'b0;  // pulse is one cycle
      sys_ren_i = 1'b0;
      wait_cyc++;
      @(negedge adc_clk);
    end
    rdata     = sys_rdata_o;
    sys_wen_i = 1'b0;
    sys_ren_i = 1'b0;
    if (!sys_ack_o)
    begin
      $display("bus access to 0x%h got no ack within 16 cycles", addr);
      bus_errs++;
    end
  endtask

  task automatic read_check(input logic [31:0] addr, input logic [31:0] exp);
    logic [31:0] got;
    bus_access(1'b0, addr, 32'h0, got);
    bus_checks++;
    if (got !== exp)
    begin
      $display("[ERROR] sys_rdata_o at 0x%h = 0x%h, expected 0x%h", addr, got, exp);
      bus_errs++;
    end
  endtask

  initial
  begin
    sys_addr_i  = '0;
    sys_wdata_i = '0;
    sys_wen_i   = 1'b0;
    sys_ren_i   = 1'b0;
    #1 rst_n_i  = 1'b0;                 // real falling edge on the async reset
    repeat (RST_CYC) @(negedge adc_clk);
    rst_n_i = 1'b1;
    repeat (PHASE_CYC) @(negedge adc_clk);  // loopback off
    read_check(32'h0, rp_fe_pkg::HK_ID_VALUE);
    read_check(32'h8, 32'h0);           // unmapped offset
    for (int r = 1; r < rp_fe_pkg::N_REGION; r++)
    begin
      // loop flag offset in a foreign region, must not reach housekeeping
      bus_access(1'b1, (r << rp_fe_pkg::REGION_LSB) | 4, 32'h1, rd);
      read_check((r << rp_fe_pkg::REGION_LSB) | 4, 32'h0);
    end
    read_check(32'h4, 32'h0);           // loop flag still clear after reset
    bus_access(1'b1, 32'h4, 32'h1, rd);  // loopback on
    read_check(32'h4, 32'h1);
    repeat (PHASE_CYC) @(negedge adc_clk);
    bus_access(1'b1, 32'h4, 32'h0, rd);  // and off again
    read_check(32'h4, 32'h0);
    repeat (PHASE_CYC) @(negedge adc_clk);
    $display("bus reads %0d, bus errors %0d, assertion failures %0d",
             bus_checks, bus_errs, UUT.u_props.fail_cnt);
    if (bus_errs == 0 && UUT.u_props.fail_cnt == 0)
      $display("Test passed");
    else
      $display("Test failed");
    $finish;
  end

  // run limit
  always @(posedge adc_clk)
  begin
    cycles++;
    if (cycles >= LIMIT_CYC)
    begin
      $display("timeout, run did not finish within %0d cycles", LIMIT_CYC);
      $display("Test failed");
      $finish;
    end
  end

endmodule : rp_frontend_tb

//--- flist.f
rp_fe_pkg.sv
adc_input_stage.sv
dac_mixer.sv
sys_bus_decoder.sv
housekeeping_regs.sv
rp_frontend_top.sv
rp_frontend_props.sv
rp_frontend_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# builds the front end testbench with Verilator and runs it
# pass or fail is taken from the simulation log

set -u
cd "$(dirname "$0")" || exit 1

log=sim.log

verilator --binary --timing --assert --top-module rp_frontend_tb \
  -f flist.f -o rp_frontend_sim
if [ $? -ne 0 ]; then
  echo "verilator build failed"
  exit 1
fi

# let the run continue past assertion errors so the summary is printed
./obj_dir/rp_frontend_sim +verilator+error+limit+1000 > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "Test passed" "$log"; then
  exit 0
fi
echo "pass message not found in $log"
exit 1
